// ==== common/dummy_pkg.sv ====
// Shared constants and types for the dummy instruction inserter.
// Only the RV32 base and M encodings needed for ADD, AND, MUL and BLTU are kept.
// The LFSR tap mask describes a right-shifting Galois LFSR of LFSR_W bits.

package dummy_pkg;

  // Data path widths
  localparam int unsigned INSTR_W = 32;
  localparam int unsigned LFSR_W  = 32;
  localparam int unsigned FREQ_W  = 4;

  localparam logic [4:0] REG_X0 = 5'd0;

  // Major opcodes
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

  // The funct3 field for the four dummy kinds
  localparam logic [2:0] FUNCT3_ADD  = 3'b000;
  localparam logic [2:0] FUNCT3_AND  = 3'b111;
  localparam logic [2:0] FUNCT3_MUL  = 3'b000;
  localparam logic [2:0] FUNCT3_BLTU = 3'b110;

  // MUL shares funct3 with ADD and is told apart by funct7
  localparam logic [6:0] FUNCT7_ADD = 7'b0000000;
  localparam logic [6:0] FUNCT7_AND = 7'b0000000;
  localparam logic [6:0] FUNCT7_MUL = 7'b0000001;

  // Maximal length feedback polynomial, bit 31 must stay set
  localparam logic [LFSR_W-1:0] LFSR_TAPS = 32'h8000_0057;

  // Default seeds, all nonzero
  localparam logic [LFSR_W-1:0] LFSR0_SEED = 32'h7A5F_3C19;
  localparam logic [LFSR_W-1:0] LFSR1_SEED = 32'h1B2E_9D47;
  localparam logic [LFSR_W-1:0] LFSR2_SEED = 32'hC603_E581;

  // Kind of dummy instruction, picked from two LFSR0 bits
  typedef enum logic [1:0] {
    DUMMY_ADD  = 2'd0,
    DUMMY_AND  = 2'd1,
    DUMMY_MUL  = 2'd2,
    DUMMY_BLTU = 2'd3
  } dummy_kind_e;

  // Target of a seed write, encoding 3 is ignored
  typedef enum logic [1:0] {
    SEL_LFSR0 = 2'd0,
    SEL_LFSR1 = 2'd1,
    SEL_LFSR2 = 2'd2
  } lfsr_sel_e;

endpackage

// ==== design/dummy_lfsr.sv ====
// Seedable Galois LFSR with lockup protection.
// A seed write takes priority over a step in the same cycle.
// Any load that would leave the register at zero takes DefaultSeed instead,
// so the output is never zero out of reset.

`timescale 1ns/1ns

module dummy_lfsr import dummy_pkg::*; #(
  parameter logic [LFSR_W-1:0] DefaultSeed = LFSR0_SEED
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              step_i,
  input  logic              seed_we_i,
  input  logic [LFSR_W-1:0] seed_i,
  output logic [LFSR_W-1:0] lfsr_o
);

  logic [LFSR_W-1:0] lfsr_q;
  logic [LFSR_W-1:0] lfsr_step;
  logic [LFSR_W-1:0] lfsr_load;
  logic [LFSR_W-1:0] lfsr_d;
  logic              lockup;

  // Shift right and fold the taps back in when a one drops out
  always_comb begin
    lfsr_step = {1'b0, lfsr_q[LFSR_W-1:1]};
    if (lfsr_q[0]) begin
      lfsr_step = lfsr_step ^ LFSR_TAPS;
    end
  end

  // Candidate value, the written seed wins over the next state
  assign lfsr_load = seed_we_i ? seed_i : lfsr_step;
  assign lockup    = (lfsr_load == '0);

  always_comb begin
    lfsr_d = lfsr_q;
    if (seed_we_i || step_i) begin
      lfsr_d = lockup ? DefaultSeed : lfsr_load;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      lfsr_q <= DefaultSeed;
    end else begin
      lfsr_q <= lfsr_d;
    end
  end

  assign lfsr_o = lfsr_q;

  // A zero state would freeze the generator for good
  a_lfsr_nonzero: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    lfsr_q != '0
  ) else $error("LFSR locked up at zero");

endmodule

// ==== design/dummy_sched.sv ====
// Dummy instruction scheduler.
// Counts accepted normal instructions and raises due_o once the count reaches
// the current gap. The gap lies in 1..N, N being set by the frequency field.
// While disabled, count and gap are cleared and the gap falls back to N.
// A lowered frequency clamps both count and gap to the new N.

`timescale 1ns/1ns

module dummy_sched import dummy_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              dummy_en_i,
  input  logic [FREQ_W-1:0] dummy_freq_i,
  input  logic              accept_i,
  input  logic              issue_i,
  input  logic [5:0]        rand_i,
  output logic              due_o
);

  // Counts up to 64 need 7 bits
  logic [6:0] n;
  logic [5:0] gap_mask;
  logic [6:0] gap_eff;
  logic [6:0] gap_q;
  logic [6:0] count_q;
  logic [6:0] count_next;

  // The highest set bit of the frequency field selects N
  always_comb begin
    if (dummy_freq_i[3]) begin
      n = 7'd64;
    end else if (dummy_freq_i[2]) begin
      n = 7'd32;
    end else if (dummy_freq_i[1]) begin
      n = 7'd16;
    end else if (dummy_freq_i[0]) begin
      n = 7'd8;
    end else begin
      n = 7'd4;
    end
  end

  // N is a power of two, so N-1 masks the random draw into 0..N-1
  assign gap_mask = 6'(n - 7'd1);

  // A stored gap of zero stands for N
  assign gap_eff = ((gap_q == '0) || (gap_q > n)) ? n : gap_q;

  assign due_o = (count_q >= gap_eff);

  always_comb begin
    count_next = count_q;
    if (issue_i) begin
      count_next = '0;
    end else if (accept_i) begin
      count_next = count_q + 7'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni || !dummy_en_i) begin
      count_q <= '0;
      gap_q   <= '0;
    end else begin
      count_q <= (count_next > n) ? n : count_next;
      if (issue_i) begin
        gap_q <= {1'b0, rand_i & gap_mask} + 7'd1;
      end
    end
  end

  // Holds once the setting has been steady for a cycle
  a_count_le_n: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $stable(dummy_freq_i) |-> count_q <= n
  ) else $error("Scheduler count 0x%0h exceeds N 0x%0h", count_q, n);

endmodule

// ==== design/dummy_encoder.sv ====
// Dummy instruction encoder, purely combinational.
// LFSR0 bits [7:6] pick the kind, [12:8] give rs1 and [17:13] give rs2.
// Bits [5:0] feed the scheduler and the remaining bits are not used here.
// ALU kinds write x0; the BLTU kind has a zero offset in every immediate bit.

`timescale 1ns/1ns

module dummy_encoder import dummy_pkg::*; (
  input  logic [LFSR_W-1:0]  rand_i,
  output logic [INSTR_W-1:0] instr_o
);

  dummy_kind_e kind;
  logic [4:0]  rs1;
  logic [4:0]  rs2;

  assign kind = dummy_kind_e'(rand_i[7:6]);
  assign rs1  = rand_i[12:8];
  assign rs2  = rand_i[17:13];

  // R-type layout is funct7, rs2, rs1, funct3, rd, opcode
  // B-type keeps the same rs and funct3 positions with the immediate split
  // across bits [31:25] and [11:7]
  always_comb begin
    unique case (kind)
      DUMMY_ADD: begin
        instr_o = {FUNCT7_ADD, rs2, rs1, FUNCT3_ADD, REG_X0, OPCODE_OP};
      end
      DUMMY_AND: begin
        instr_o = {FUNCT7_AND, rs2, rs1, FUNCT3_AND, REG_X0, OPCODE_OP};
      end
      DUMMY_MUL: begin
        instr_o = {FUNCT7_MUL, rs2, rs1, FUNCT3_MUL, REG_X0, OPCODE_OP};
      end
      DUMMY_BLTU: begin
        instr_o = {7'b0, rs2, rs1, FUNCT3_BLTU, 5'b0, OPCODE_BRANCH};
      end
      default: begin
        instr_o = {FUNCT7_ADD, rs2, rs1, FUNCT3_ADD, REG_X0, OPCODE_OP};
      end
    endcase
  end

endmodule

// ==== design/dummy_insert.sv ====
// Dummy instruction inserter between fetch and decode.
// Fetch uses valid/ready; ready drops only in a cycle that issues a dummy,
// and the fetch unit must then hold its word. Decode gets a one-cycle strobe
// with no back-pressure, one cycle after the accept or the issue.
// The operand outputs are only meaningful together with id_dummy_o.

`timescale 1ns/1ns

module dummy_insert import dummy_pkg::*; #(
  parameter logic [LFSR_W-1:0] Lfsr0Seed = LFSR0_SEED,
  parameter logic [LFSR_W-1:0] Lfsr1Seed = LFSR1_SEED,
  parameter logic [LFSR_W-1:0] Lfsr2Seed = LFSR2_SEED
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               dummy_en_i,
  input  logic [FREQ_W-1:0]  dummy_freq_i,
  input  logic               fetch_valid_i,
  input  logic [INSTR_W-1:0] fetch_instr_i,
  output logic               fetch_ready_o,
  input  logic               seed_we_i,
  input  lfsr_sel_e          seed_sel_i,
  input  logic [LFSR_W-1:0]  seed_i,
  output logic               id_valid_o,
  output logic [INSTR_W-1:0] id_instr_o,
  output logic               id_dummy_o,
  output logic [LFSR_W-1:0]  id_operand_a_o,
  output logic [LFSR_W-1:0]  id_operand_b_o
);

  logic               due;
  logic               issue;
  logic               accept;
  logic [2:0]         seed_we;
  logic [LFSR_W-1:0]  lfsr0;
  logic [LFSR_W-1:0]  lfsr1;
  logic [LFSR_W-1:0]  lfsr2;
  logic [INSTR_W-1:0] dummy_instr;

  // A dummy takes the slot of the waiting fetch word
  assign issue         = fetch_valid_i && dummy_en_i && due;
  assign fetch_ready_o = !issue;
  assign accept        = fetch_valid_i && fetch_ready_o;

  assign seed_we[0] = seed_we_i && (seed_sel_i == SEL_LFSR0);
  assign seed_we[1] = seed_we_i && (seed_sel_i == SEL_LFSR1);
  assign seed_we[2] = seed_we_i && (seed_sel_i == SEL_LFSR2);

  // All three generators advance once per issued dummy
  dummy_lfsr #(.DefaultSeed(Lfsr0Seed)) u_lfsr0 (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .step_i    (issue),
    .seed_we_i (seed_we[0]),
    .seed_i    (seed_i),
    .lfsr_o    (lfsr0)
  );

  dummy_lfsr #(.DefaultSeed(Lfsr1Seed)) u_lfsr1 (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .step_i    (issue),
    .seed_we_i (seed_we[1]),
    .seed_i    (seed_i),
    .lfsr_o    (lfsr1)
  );

  dummy_lfsr #(.DefaultSeed(Lfsr2Seed)) u_lfsr2 (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .step_i    (issue),
    .seed_we_i (seed_we[2]),
    .seed_i    (seed_i),
    .lfsr_o    (lfsr2)
  );

  dummy_sched u_sched (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .dummy_en_i   (dummy_en_i),
    .dummy_freq_i (dummy_freq_i),
    .accept_i     (accept),
    .issue_i      (issue),
    .rand_i       (lfsr0[5:0]),
    .due_o        (due)
  );

  dummy_encoder u_encoder (
    .rand_i  (lfsr0),
    .instr_o (dummy_instr)
  );

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      id_valid_o <= 1'b0;
      id_dummy_o <= 1'b0;
    end else begin
      id_valid_o <= accept || issue;
      id_dummy_o <= issue;
    end
  end

  // Payload carries no reset and only loads with a valid slot
  always_ff @(posedge clk_i) begin
    if (accept || issue) begin
      id_instr_o <= issue ? dummy_instr : fetch_instr_i;
    end
    // Operands are the LFSR values from before this issue's step
    if (issue) begin
      id_operand_a_o <= lfsr1;
      id_operand_b_o <= lfsr2;
    end
  end

  a_dummy_implies_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    id_dummy_o |-> id_valid_o && $past(!fetch_ready_o)
  ) else $error("id_dummy_o set without a valid issue slot");

endmodule

// ==== dv/tb_dummy_checks.sv ====
// Concurrent checks on the fetch and decode sides of the dummy inserter.
// Assumes each new fetch word carries an incrementing tag in bits [31:16].
// Assumes the DUT runs with the package default seeds.
// A failed check prints an error line and raises fail_o for the testbench top.

`timescale 1ns/1ns

module tb_dummy_checks import dummy_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               dummy_en_i,
  input  logic [FREQ_W-1:0]  dummy_freq_i,
  input  logic               fetch_valid_i,
  input  logic [INSTR_W-1:0] fetch_instr_i,
  input  logic               ready_i,
  input  logic               seed_we_i,
  input  lfsr_sel_e          seed_sel_i,
  input  logic [LFSR_W-1:0]  seed_i,
  input  logic               id_valid_i,
  input  logic [INSTR_W-1:0] id_instr_i,
  input  logic               id_dummy_i,
  input  logic [LFSR_W-1:0]  operand_a_i,
  input  logic [LFSR_W-1:0]  operand_b_i,
  output logic               fail_o
);

  logic [INSTR_W-1:0] instr_q;
  logic [15:0]        next_tag;
  logic               en_q;
  logic [FREQ_W-1:0]  freq_q;
  logic [FREQ_W-1:0]  freq_qq;
  logic               track_ok;
  logic               gap_armed;
  int unsigned        normals;
  logic               dummy_seen;
  logic               wr_a_q;
  logic               wr_b_q;
  logic [LFSR_W-1:0]  wr_a_val;
  logic [LFSR_W-1:0]  wr_b_val;
  logic               armed_a;
  logic               armed_b;
  logic [LFSR_W-1:0]  exp_a;
  logic [LFSR_W-1:0]  exp_b;

  initial fail_o = 1'b0;

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
    fail_o = 1'b1;
  endtask

  task automatic report_text(input string what);
    $display("%s", what);
    fail_o = 1'b1;
  endtask

  // Largest gap between two dummies for a frequency setting
  function automatic int unsigned max_gap(input logic [FREQ_W-1:0] freq);
    if (freq[3]) return 64;
    if (freq[2]) return 32;
    if (freq[1]) return 16;
    if (freq[0]) return 8;
    return 4;
  endfunction

  function automatic bit legal_dummy(input logic [INSTR_W-1:0] w);
    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    opcode = w[6:0];
    f3     = w[14:12];
    f7     = w[31:25];
    if (opcode == OPCODE_OP && w[11:7] == REG_X0) begin
      return (f3 == FUNCT3_ADD && f7 == FUNCT7_ADD) ||
             (f3 == FUNCT3_AND && f7 == FUNCT7_AND) ||
             (f3 == FUNCT3_MUL && f7 == FUNCT7_MUL);
    end
    if (opcode == OPCODE_BRANCH) begin
      return f3 == FUNCT3_BLTU && f7 == 7'b0 && w[11:7] == 5'b0;
    end
    return 1'b0;
  endfunction

  assign dummy_seen = id_valid_i && id_dummy_i;
  // Output seen now was decided one cycle back, so compare the delayed settings
  assign track_ok   = en_q && (freq_q == freq_qq);

  always_ff @(posedge clk_i) begin
    instr_q <= fetch_instr_i;
    if (!rst_ni) begin
      next_tag  <= '0;
      en_q      <= 1'b0;
      freq_q    <= '0;
      freq_qq   <= '0;
      gap_armed <= 1'b0;
      normals   <= 0;
      wr_a_q    <= 1'b0;
      wr_b_q    <= 1'b0;
      armed_a   <= 1'b0;
      armed_b   <= 1'b0;
    end else begin
      en_q    <= dummy_en_i;
      freq_q  <= dummy_freq_i;
      freq_qq <= freq_q;
      if (id_valid_i && !id_dummy_i) begin
        next_tag <= next_tag + 16'd1;
      end
      if (!track_ok) begin
        gap_armed <= 1'b0;
        normals   <= 0;
      end else if (dummy_seen) begin
        gap_armed <= 1'b1;
        normals   <= 0;
      end else if (id_valid_i) begin
        normals <= normals + 1;
      end
      // A zero seed falls back to the default one
      wr_a_q   <= seed_we_i && (seed_sel_i == SEL_LFSR1);
      wr_b_q   <= seed_we_i && (seed_sel_i == SEL_LFSR2);
      wr_a_val <= (seed_i == '0) ? LFSR1_SEED : seed_i;
      wr_b_val <= (seed_i == '0) ? LFSR2_SEED : seed_i;
      if (wr_a_q) begin
        armed_a <= 1'b1;
        exp_a   <= wr_a_val;
      end else if (dummy_seen) begin
        armed_a <= 1'b0;
      end
      if (wr_b_q) begin
        armed_b <= 1'b1;
        exp_b   <= wr_b_val;
      end else if (dummy_seen) begin
        armed_b <= 1'b0;
      end
    end
  end

  a_ready_when_off: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !dummy_en_i |-> ready_i
  ) else report_value("fetch_ready_o", $sampled(ready_i), 32'h1);

  a_no_dummy_when_off: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !dummy_en_i |=> !id_dummy_i
  ) else report_value("id_dummy_o", $sampled(id_dummy_i), 32'h0);

  a_ready_low_needs_issue: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !ready_i |-> fetch_valid_i && dummy_en_i
  ) else report_value("fetch_valid_i", $sampled(fetch_valid_i), 32'h1);

  a_issue_gives_dummy: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    fetch_valid_i && !ready_i |=> id_valid_i && id_dummy_i
  ) else report_value("id_dummy_o", $sampled(id_dummy_i), 32'h1);

  a_accept_gives_normal: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    fetch_valid_i && ready_i |=> id_valid_i && !id_dummy_i
  ) else report_value("id_valid_o", $sampled(id_valid_i), 32'h1);

  a_accept_passes_word: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    fetch_valid_i && ready_i |=> id_instr_i == instr_q
  ) else report_value("id_instr_o", $sampled(id_instr_i), $sampled(instr_q));

  a_idle_no_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !fetch_valid_i |=> !id_valid_i
  ) else report_value("id_valid_o", $sampled(id_valid_i), 32'h0);

  a_normal_in_order: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    id_valid_i && !id_dummy_i |-> id_instr_i[31:16] == next_tag
  ) else report_value("id_instr_o tag", $sampled(id_instr_i[31:16]), $sampled(next_tag));

  a_dummy_legal: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    dummy_seen |-> legal_dummy(id_instr_i)
  ) else report_text($sformatf("Error: id_instr_o 0x%08h is not a legal dummy",
                               $sampled(id_instr_i)));

  a_gap_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    dummy_seen && gap_armed && track_ok |-> normals >= 1 && normals <= max_gap(freq_q)
  ) else report_text($sformatf("Error: dummy gap 0x%0h outside 0x1 to 0x%0h",
                               $sampled(normals), max_gap($sampled(freq_q))));

  a_seed_operand_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    dummy_seen && armed_a |-> operand_a_i == exp_a
  ) else report_value("id_operand_a_o", $sampled(operand_a_i), $sampled(exp_a));

  a_seed_operand_b: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    dummy_seen && armed_b |-> operand_b_i == exp_b
  ) else report_value("id_operand_b_o", $sampled(operand_b_i), $sampled(exp_b));

endmodule

// ==== dv/tb_dummy_insert.sv ====
// Testbench top for the dummy instruction inserter.
// New fetch words carry an incrementing tag in bits [31:16] for the checker.
// Runs disabled, then enabled at five frequency settings, then seed writes.

`timescale 1ns/1ns

module tb_dummy_insert import dummy_pkg::*; ();

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 4;
  localparam int OFF_CYCLES   = 200;
  localparam int FREQ_CLASSES = 5;
  localparam int FREQ_CYCLES  = 400;
  localparam int SEED_BUDGET  = 400;
  localparam int WATCHDOG_CYCLES =
    RESET_CYCLES + OFF_CYCLES + FREQ_CLASSES * FREQ_CYCLES + SEED_BUDGET + 500;

  logic               clk_i;
  logic               rst_ni;
  logic               dummy_en_i;
  logic [FREQ_W-1:0]  dummy_freq_i;
  logic               fetch_valid_i;
  logic [INSTR_W-1:0] fetch_instr_i;
  logic               fetch_ready_o;
  logic               seed_we_i;
  lfsr_sel_e          seed_sel_i;
  logic [LFSR_W-1:0]  seed_i;
  logic               id_valid_o;
  logic [INSTR_W-1:0] id_instr_o;
  logic               id_dummy_o;
  logic [LFSR_W-1:0]  id_operand_a_o;
  logic [LFSR_W-1:0]  id_operand_b_o;
  logic               chk_fail;
  logic [15:0]        tag;
  int                 dummy_count;

  dummy_insert u_dummy_insert (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .dummy_en_i     (dummy_en_i),
    .dummy_freq_i   (dummy_freq_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_instr_i  (fetch_instr_i),
    .fetch_ready_o  (fetch_ready_o),
    .seed_we_i      (seed_we_i),
    .seed_sel_i     (seed_sel_i),
    .seed_i         (seed_i),
    .id_valid_o     (id_valid_o),
    .id_instr_o     (id_instr_o),
    .id_dummy_o     (id_dummy_o),
    .id_operand_a_o (id_operand_a_o),
    .id_operand_b_o (id_operand_b_o)
  );

  tb_dummy_checks u_checks (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .dummy_en_i    (dummy_en_i),
    .dummy_freq_i  (dummy_freq_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_instr_i (fetch_instr_i),
    .ready_i       (fetch_ready_o),
    .seed_we_i     (seed_we_i),
    .seed_sel_i    (seed_sel_i),
    .seed_i        (seed_i),
    .id_valid_i    (id_valid_o),
    .id_instr_i    (id_instr_o),
    .id_dummy_i    (id_dummy_o),
    .operand_a_i   (id_operand_a_o),
    .operand_b_i   (id_operand_b_o),
    .fail_o        (chk_fail)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // One setting per class of the highest set bit, with extra low bits mixed in
  function automatic logic [FREQ_W-1:0] freq_for_class(input int k);
    case (k)
      0:       return 4'h0;
      1:       return 4'h1;
      2:       return 4'h3;
      3:       return 4'h6;
      default: return 4'hB;
    endcase
  endfunction

  // Handshake is sampled mid cycle, inputs change 1 ns after the rising edge
  task automatic run_cycles(input int n);
    bit took;
    bit held;
    for (int i = 0; i < n; i++) begin
      @(negedge clk_i);
      took = fetch_valid_i && fetch_ready_o;
      held = fetch_valid_i && !fetch_ready_o;
      if (id_valid_o && id_dummy_o) begin
        dummy_count++;
      end
      @(posedge clk_i);
      #1;
      seed_we_i = 1'b0;
      if (took) begin
        tag = tag + 16'd1;
        fetch_instr_i = {tag, 16'($urandom)};
      end
      // A word refused for a dummy stays on the bus with valid high
      if (!held) begin
        fetch_valid_i = ($urandom % 4) != 0;
      end
    end
  endtask

  task automatic write_seed(input lfsr_sel_e sel, input logic [LFSR_W-1:0] value);
    int start;
    seed_we_i  = 1'b1;
    seed_sel_i = sel;
    seed_i     = value;
    start      = dummy_count;
    run_cycles(1);
    while (dummy_count < start + 2) begin
      run_cycles(1);
    end
  endtask

  initial begin
    wait (chk_fail === 1'b1);
    $display("SIMULATION FAILED");
    $fatal(1, "A check in tb_dummy_checks failed");
  end

  initial begin
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $fatal(1, "Watchdog expired before the test sequence finished");
  end

  initial begin
    void'($urandom(75061));
    rst_ni        = 1'b0;
    dummy_en_i    = 1'b0;
    dummy_freq_i  = '0;
    fetch_valid_i = 1'b0;
    tag           = '0;
    fetch_instr_i = {tag, 16'($urandom)};
    seed_we_i     = 1'b0;
    seed_sel_i    = SEL_LFSR0;
    seed_i        = '0;
    dummy_count   = 0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    run_cycles(OFF_CYCLES);

    dummy_en_i = 1'b1;
    for (int k = 0; k < FREQ_CLASSES; k++) begin
      dummy_freq_i = freq_for_class(k);
      run_cycles(FREQ_CYCLES);
    end

    // Smallest gap keeps dummies frequent while seeds are written
    dummy_freq_i = 4'h0;
    write_seed(SEL_LFSR1, 32'h1234_5678);
    write_seed(SEL_LFSR2, 32'hDEAD_BEEF);
    write_seed(SEL_LFSR1, 32'h0);
    write_seed(SEL_LFSR2, 32'h0);
    write_seed(SEL_LFSR0, 32'h0);
    write_seed(SEL_LFSR0, 32'hA5A5_0F0F);
    run_cycles(20);

    if (chk_fail || dummy_count == 0) begin
      $display("SIMULATION FAILED");
      $fatal(1, "Run ended after a failed check or without any dummy");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

// ==== verilog.f ====
common/dummy_pkg.sv
design/dummy_lfsr.sv
design/dummy_sched.sv
design/dummy_encoder.sv
design/dummy_insert.sv
dv/tb_dummy_checks.sv
dv/tb_dummy_insert.sv
